// ==== tb.f ====
+incdir+include
verilog/pkg_tpu.sv
verilog/instr_buffer.sv
verilog/ifetch.sv
verilog/decode.sv
verilog/exec_unit.sv
verilog/seq_control.sv
verilog/tpu_lane.sv
bench/tb_tpu_lane.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the tensor lane testbench with Verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module tb_tpu_lane -f tb.f; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_tpu_lane)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi

// ==== bench/tb_tpu_lane.sv ====
// Testbench for the tensor lane with loader, reference model, comparator and watchdog
`timescale 1ns/1ps
`include "tpu_macros.svh"

module tb_tpu_lane
	import pkg_tpu::*;
();

	localparam int CLK_HALF			= 4;			// 8 ns period
	localparam int PROG_WORDS		= 13 + 10 + 11 + 3;	// All programs together
	localparam int TIMEOUT_CYCLES	= PROG_WORDS * 10 + 300;

	logic						clock;
	logic						reset;
	logic						start;
	logic						wr_en;
	logic [`TPU_INSTR_W-1:0]	wr_instr;
	logic						full;
	logic						busy;
	logic						done;
	logic						wb_valid;
	logic [`TPU_REG_AW-1:0]		wb_addr;
	logic [`TPU_DATA_W-1:0]		wb_data;

	integer						seed;
	logic [`TPU_INSTR_W-1:0]	prog [$];			// Program being loaded
	logic [`TPU_DATA_W-1:0]		model_regs [0:`TPU_REG_N-1];
	logic [`TPU_REG_AW-1:0]		exp_addr [$];		// Expected write-backs in order
	logic [`TPU_DATA_W-1:0]		exp_data [$];
	logic [`TPU_REG_AW-1:0]		e_addr;
	logic [`TPU_DATA_W-1:0]		e_data;
	int							exp_total;
	int							wb_count;
	int							chk_checks, chk_errors;	// Test process
	int							cmp_checks, cmp_errors;	// Compare process
	int							tests_run;
	int							err_mark;

	tpu_lane u_dut (
		.clock		(clock),
		.reset		(reset),
		.start		(start),
		.wr_en		(wr_en),
		.wr_instr	(wr_instr),
		.full		(full),
		.busy		(busy),
		.done		(done),
		.wb_valid	(wb_valid),
		.wb_addr	(wb_addr),
		.wb_data	(wb_data)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_HALF) clock = ~clock;
	end

	////////////////////////////////////////
	// Instruction word from its fields
	function automatic logic [31:0] make_instr(input logic [3:0] opc, input logic [2:0] dst,
			input logic [2:0] a, input logic [2:0] b, input logic [15:0] imm);
		return {opc, 1'b0, dst, 1'b0, a, 1'b0, b, imm};
	endfunction

	// Expected result for one opcode
	function automatic logic [31:0] ref_result(input logic [3:0] opc, input logic [31:0] a,
			input logic [31:0] b, input logic [31:0] d, input logic [15:0] imm);
		case (opc)
			ADD:		return a + b;
			SUB:		return a - b;
			MUL:		return a * b;			// Low word
			AND:		return a & b;
			OR:			return a | b;
			XOR:		return a ^ b;
			SHL:		return a << b[4:0];
			LDI:		return {16'h0000, imm};
			default:	return d;				// NOP and unused codes
		endcase
	endfunction

	// Walks the program up to the first HALT and queues write-backs
	task automatic expect_program();
		logic [3:0]		opc;
		logic [2:0]		dst;
		logic [31:0]	res;
		for (int i = 0; i < prog.size(); i++) begin
			opc = prog[i][`TPU_OPC_HI:`TPU_OPC_LO];
			if (opc == 4'(HALT))
				break;
			dst = prog[i][`TPU_DST_HI:`TPU_DST_LO];
			res = ref_result(opc, model_regs[prog[i][`TPU_SRCA_HI:`TPU_SRCA_LO]],
				model_regs[prog[i][`TPU_SRCB_HI:`TPU_SRCB_LO]], model_regs[dst],
				prog[i][`TPU_IMM_HI:`TPU_IMM_LO]);
			model_regs[dst] = res;
			exp_addr.push_back(dst);
			exp_data.push_back(res);
			exp_total++;
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (2) @(posedge clock);
		#1 reset = 1'b0;
		for (int i = 0; i < `TPU_REG_N; i++)
			model_regs[i] = '0;				// Mirrors the register file reset
	endtask

	// Loads while idle, then one start pulse
	task automatic load_and_start();
		expect_program();
		while (busy)
			@(posedge clock);
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clock);
			#1 wr_en = 1'b1;
			wr_instr = prog[i];
		end
		@(posedge clock);
		#1 wr_en = 1'b0;
		start = 1'b1;
		@(posedge clock);
		#1 start = 1'b0;
	endtask

	task automatic check_true(input bit cond, input string what);
		chk_checks++;
		assert (cond) else begin
			$display("Error %0d ns: %s", $time, what);
			chk_errors++;
		end
	endtask

	task automatic wait_done();
		do @(negedge clock); while (!done);
		@(negedge clock);					// Let the compare process settle
		check_true(exp_addr.size() == 0,
			$sformatf("%0d expected write-backs never appeared", exp_addr.size()));
	endtask

	task automatic finish_test(input string name);
		int n;
		n = chk_errors + cmp_errors - err_mark;
		tests_run++;
		$display("Test %0d %s: %s (%0d errors)", tests_run, name, (n == 0) ? "ok" : "bad", n);
		err_mark = chk_errors + cmp_errors;
	endtask

	////////////////////////////////////////
	// Compare process, one entry per strobe
	always @(negedge clock) begin
		if (!reset && wb_valid) begin
			wb_count++;
			cmp_checks++;
			assert (exp_addr.size() != 0) else begin
				$display("At %0d ns: write-back to r%0d arrived with nothing expected",
					$time, wb_addr);
				cmp_errors++;
			end
			if (exp_addr.size() != 0) begin
				e_addr = exp_addr.pop_front();
				e_data = exp_data.pop_front();
				assert (wb_addr == e_addr && wb_data == e_data) else begin
					$display("Error %0d ns: expected r%0d = %h, got r%0d = %h",
						$time, e_addr, e_data, wb_addr, wb_data);
					cmp_errors++;
				end
			end
		end
	end

	// Watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	////////////////////////////////////////
	// Tests
	initial begin
		logic [31:0]	r;
		logic [3:0]		op;
		int				wb_mark;
		int				exp_mark;
		seed		= 32'hcd6a_e42d;
		start		= 1'b0;
		wr_en		= 1'b0;
		wr_instr	= '0;
		exp_total	= 0;
		wb_count	= 0;
		chk_checks	= 0;
		chk_errors	= 0;
		cmp_checks	= 0;
		cmp_errors	= 0;
		tests_run	= 0;
		err_mark	= 0;
		apply_reset();

		// Quiet outputs after reset
		@(negedge clock);
		check_true(!busy, "busy is high after reset");
		check_true(!done, "done is high after reset");
		check_true(!wb_valid, "wb_valid is high after reset");
		check_true(!full, "full is high after reset");
		finish_test("reset state");

		// Four loads, then each ALU opcode and a NOP, random registers
		prog.delete();
		for (int i = 0; i < 12; i++) begin
			r = $random(seed);
			if (i < 4)
				op = LDI;
			else if (i == 11)
				op = NOP;
			else
				op = 4'(i - 3);				// ADD through SHL
			prog.push_back(make_instr(op, r[2:0], r[6:4], r[10:8], r[31:16]));
		end
		prog.push_back(make_instr(HALT, 3'd0, 3'd0, 3'd0, 16'h0000));
		load_and_start();
		wait_done();
		finish_test("random program");

		// Each step reads the previous destination
		prog.delete();
		prog.push_back(make_instr(LDI, 3'd1, 3'd0, 3'd0, 16'h0003));
		prog.push_back(make_instr(ADD, 3'd2, 3'd1, 3'd1, 16'h0000));
		prog.push_back(make_instr(MUL, 3'd3, 3'd2, 3'd2, 16'h0000));
		prog.push_back(make_instr(SUB, 3'd4, 3'd3, 3'd1, 16'h0000));
		prog.push_back(make_instr(SHL, 3'd5, 3'd4, 3'd1, 16'h0000));
		prog.push_back(make_instr(XOR, 3'd6, 3'd5, 3'd4, 16'h0000));
		prog.push_back(make_instr(OR, 3'd7, 3'd6, 3'd5, 16'h0000));
		prog.push_back(make_instr(AND, 3'd0, 3'd7, 3'd6, 16'h0000));
		prog.push_back(make_instr(4'hc, 3'd0, 3'd0, 3'd0, 16'hffff));	// Unused code
		prog.push_back(make_instr(HALT, 3'd0, 3'd0, 3'd0, 16'h0000));
		load_and_start();
		wait_done();
		finish_test("dependent chain");

		// Words behind HALT must vanish with the flush
		wb_mark		= wb_count;
		exp_mark	= exp_total;
		prog.delete();
		prog.push_back(make_instr(LDI, 3'd1, 3'd0, 3'd0, 16'h0011));
		prog.push_back(make_instr(LDI, 3'd2, 3'd0, 3'd0, 16'h0022));
		prog.push_back(make_instr(ADD, 3'd3, 3'd1, 3'd2, 16'h0000));
		prog.push_back(make_instr(HALT, 3'd0, 3'd0, 3'd0, 16'h0000));
		prog.push_back(make_instr(LDI, 3'd5, 3'd0, 3'd0, 16'hdead));
		prog.push_back(make_instr(ADD, 3'd6, 3'd5, 3'd5, 16'h0000));
		prog.push_back(make_instr(LDI, 3'd4, 3'd0, 3'd0, 16'hbeef));	// Last read-ahead
		prog.push_back(make_instr(SUB, 3'd7, 3'd5, 3'd6, 16'h0000));	// Still buffered
		prog.push_back(make_instr(LDI, 3'd3, 3'd0, 3'd0, 16'hf00d));
		load_and_start();
		wait_done();
		repeat (5) @(negedge clock);
		prog.delete();
		prog.push_back(make_instr(LDI, 3'd7, 3'd0, 3'd0, 16'h1234));
		prog.push_back(make_instr(HALT, 3'd0, 3'd0, 3'd0, 16'h0000));
		load_and_start();
		wait_done();
		check_true(wb_count - wb_mark == exp_total - exp_mark,
			"write-back count differs from the instructions before HALT");
		finish_test("squash after halt");

		// No HALT, so the lane stays busy on an empty buffer
		wb_mark		= wb_count;
		exp_mark	= exp_total;
		prog.delete();
		prog.push_back(make_instr(LDI, 3'd1, 3'd0, 3'd0, 16'h0055));
		prog.push_back(make_instr(LDI, 3'd2, 3'd0, 3'd0, 16'h00aa));
		prog.push_back(make_instr(ADD, 3'd3, 3'd1, 3'd2, 16'h0000));
		load_and_start();
		repeat (20) @(negedge clock);
		check_true(busy, "busy dropped while the buffer ran empty");
		check_true(wb_count - wb_mark == exp_total - exp_mark,
			"write-back count is wrong after the buffer ran empty");
		repeat (10) @(negedge clock);
		check_true(wb_count - wb_mark == exp_total - exp_mark,
			"lane produced extra write-backs while idling on an empty buffer");
		check_true(exp_addr.size() == 0, "expected write-backs still pending while idling");
		@(posedge clock);
		#1 apply_reset();
		@(negedge clock);
		check_true(!busy, "busy still high after the closing reset");
		finish_test("empty buffer mid-program");

		$display("Tests %0d, checks %0d, errors %0d", tests_run,
			chk_checks + cmp_checks, chk_errors + cmp_errors);
		if (chk_errors + cmp_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end
		else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog/tpu_lane.sv ====
// Top level of one tensor lane with buffer, fetch, decode, execute and sequencer
`timescale 1ns/1ps
`include "tpu_macros.svh"

module tpu_lane
	import pkg_tpu::*;
(
	input	logic						clock,
	input	logic						reset,
	input	logic						start,
	input	logic						wr_en,			// Load while idle
	input	logic [`TPU_INSTR_W-1:0]	wr_instr,
	output	logic						full,
	output	logic						busy,
	output	logic						done,
	output	logic						wb_valid,
	output	logic [`TPU_REG_AW-1:0]		wb_addr,
	output	logic [`TPU_DATA_W-1:0]		wb_data
);

	// Sequencer
	logic						run;
	logic						flush;

	// Buffer to fetch
	logic						empty;
	logic						rd_en;
	logic [`TPU_INSTR_W-1:0]	rd_data;

	// Fetch to decode
	logic						fetch_valid;
	logic [`TPU_INSTR_W-1:0]	fetch_instr;

	// Decode to execute
	logic						dec_valid;
	opcode_t					dec_opcode;
	logic [`TPU_REG_AW-1:0]		dec_dst;
	logic [`TPU_REG_AW-1:0]		dec_src_a;
	logic [`TPU_REG_AW-1:0]		dec_src_b;
	logic [`TPU_IMM_W-1:0]		dec_imm;
	logic						term;

	////////////////////////////////////////
	instr_buffer u_buffer (
		.clock		(clock),
		.reset		(reset),
		.flush		(flush),
		.wr_en		(wr_en),
		.wr_instr	(wr_instr),
		.rd_en		(rd_en),
		.rd_data	(rd_data),
		.empty		(empty),
		.full		(full)
	);

	ifetch u_fetch (
		.clock			(clock),
		.reset			(reset),
		.run			(run),
		.flush			(flush),
		.empty			(empty),
		.rd_data		(rd_data),
		.rd_en			(rd_en),
		.fetch_valid	(fetch_valid),
		.fetch_instr	(fetch_instr)
	);

	decode u_decode (
		.clock			(clock),
		.reset			(reset),
		.flush			(flush),
		.fetch_valid	(fetch_valid),
		.fetch_instr	(fetch_instr),
		.dec_valid		(dec_valid),
		.dec_opcode		(dec_opcode),
		.dec_dst		(dec_dst),
		.dec_src_a		(dec_src_a),
		.dec_src_b		(dec_src_b),
		.dec_imm		(dec_imm),
		.term			(term)
	);

	exec_unit u_exec (
		.clock		(clock),
		.reset		(reset),
		.dec_valid	(dec_valid),
		.dec_opcode	(dec_opcode),
		.dec_dst	(dec_dst),
		.dec_src_a	(dec_src_a),
		.dec_src_b	(dec_src_b),
		.dec_imm	(dec_imm),
		.wb_valid	(wb_valid),
		.wb_addr	(wb_addr),
		.wb_data	(wb_data)
	);

	seq_control u_seq (
		.clock	(clock),
		.reset	(reset),
		.start	(start),
		.term	(term),
		.run	(run),
		.busy	(busy),
		.done	(done),
		.flush	(flush)
	);

endmodule

// ==== verilog/seq_control.sv ====
// Lane sequencer FSM driving run, busy, done and flush
`timescale 1ns/1ps

module seq_control
	import pkg_tpu::*;
(
	input	logic	clock,
	input	logic	reset,
	input	logic	start,		// Pulse, honored only in IDLE
	input	logic	term,		// HALT decoded
	output	logic	run,
	output	logic	busy,
	output	logic	done,
	output	logic	flush
);

	seq_state_t	state;
	seq_state_t	state_nx;

	////////////////////////////////////////
	// Next state
	always_comb begin
		state_nx	= state;
		case (state)
			IDLE:		if (start) state_nx = RUN;
			RUN:		if (term) state_nx = DONE;
			DONE:		state_nx = IDLE;		// Single cycle
			default:	state_nx = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			state	<= IDLE;
		else
			state	<= state_nx;
	end

	////////////////////////////////////////
	// Outputs decoded from state
	assign run		= (state == RUN);
	assign busy		= (state == RUN);
	assign done		= (state == DONE);
	assign flush	= (state == DONE);	// Clears buffer, fetch and decode

	// Decode only produces term while the lane runs
	a_term_in_run: assert property (@(posedge clock) disable iff (reset)
		term |-> (state == RUN));

endmodule

// ==== verilog/exec_unit.sv ====
// Register file, ALU and registered write-back report
`timescale 1ns/1ps
`include "tpu_macros.svh"

module exec_unit
	import pkg_tpu::*;
(
	input	logic						clock,
	input	logic						reset,
	input	logic						dec_valid,
	input	opcode_t					dec_opcode,
	input	logic [`TPU_REG_AW-1:0]		dec_dst,
	input	logic [`TPU_REG_AW-1:0]		dec_src_a,
	input	logic [`TPU_REG_AW-1:0]		dec_src_b,
	input	logic [`TPU_IMM_W-1:0]		dec_imm,
	output	logic						wb_valid,
	output	logic [`TPU_REG_AW-1:0]		wb_addr,
	output	logic [`TPU_DATA_W-1:0]		wb_data
);

	logic [`TPU_DATA_W-1:0]	regs [0:`TPU_REG_N-1];

	logic [`TPU_DATA_W-1:0]	op_a;
	logic [`TPU_DATA_W-1:0]	op_b;
	logic [`TPU_DATA_W-1:0]	op_d;		// Current dst value
	logic [`TPU_DATA_W-1:0]	result;

	// Combinational operand reads
	assign op_a	= regs[dec_src_a];
	assign op_b	= regs[dec_src_b];
	assign op_d	= regs[dec_dst];

	////////////////////////////////////////
	// ALU
	always_comb begin
		case (dec_opcode)
			ADD:		result	= op_a + op_b;
			SUB:		result	= op_a - op_b;
			MUL:		result	= op_a * op_b;		// Low word only
			AND:		result	= op_a & op_b;
			OR:			result	= op_a | op_b;
			XOR:		result	= op_a ^ op_b;
			SHL:		result	= op_a << op_b[4:0];
			LDI:		result	= `TPU_DATA_W'(dec_imm);	// Zero-extend
			default:	result	= op_d;				// NOP keeps dst
		endcase
	end

	////////////////////////////////////////
	// Register file, written on the write-back edge
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `TPU_REG_N; i++)
				regs[i]	<= '0;
		end
		else if (dec_valid) begin
			regs[dec_dst]	<= result;	// Next instruction reads the new value
		end
	end

	// Write-back strobe
	always_ff @(posedge clock) begin
		if (reset)
			wb_valid	<= 1'b0;
		else
			wb_valid	<= dec_valid;
	end

	// Write-back payload
	always_ff @(posedge clock) begin
		if (dec_valid) begin
			wb_addr	<= dec_dst;
			wb_data	<= result;
		end
	end

	// Decode must keep HALT out of execute
	a_no_halt_exec: assert property (@(posedge clock) disable iff (reset)
		dec_valid |-> (dec_opcode != HALT));

endmodule

// ==== verilog/decode.sv ====
// Instruction decoder with HALT detection and post-halt squash
`timescale 1ns/1ps
`include "tpu_macros.svh"

module decode
	import pkg_tpu::*;
(
	input	logic						clock,
	input	logic						reset,
	input	logic						flush,
	input	logic						fetch_valid,
	input	logic [`TPU_INSTR_W-1:0]	fetch_instr,
	output	logic						dec_valid,
	output	opcode_t					dec_opcode,
	output	logic [`TPU_REG_AW-1:0]		dec_dst,
	output	logic [`TPU_REG_AW-1:0]		dec_src_a,
	output	logic [`TPU_REG_AW-1:0]		dec_src_b,
	output	logic [`TPU_IMM_W-1:0]		dec_imm,
	output	logic						term			// HALT seen
);

	logic [`TPU_OPC_W-1:0]	raw_opc;
	opcode_t				opc;
	logic					halted;		// Set by HALT, held until flush
	logic					accept;

	assign raw_opc	= fetch_instr[`TPU_OPC_HI:`TPU_OPC_LO];
	assign accept	= fetch_valid & ~halted;

	// Legal codes pass, the rest become NOP
	always_comb begin
		case (raw_opc)
			ADD, SUB, MUL, AND, OR, XOR, SHL, LDI, HALT:
				opc	= opcode_t'(raw_opc);
			default:
				opc	= NOP;
		endcase
	end

	////////////////////////////////////////
	// Strobes and halt flag
	always_ff @(posedge clock) begin
		if (reset | flush) begin
			dec_valid	<= 1'b0;
			term		<= 1'b0;
			halted		<= 1'b0;
		end
		else begin
			dec_valid	<= accept & (opc != HALT);
			term		<= accept & (opc == HALT);	// Single pulse, halted blocks repeats
			if (accept & (opc == HALT))
				halted	<= 1'b1;
		end
	end

	// Field registers
	always_ff @(posedge clock) begin
		if (fetch_valid) begin
			dec_opcode	<= opc;
			dec_dst		<= fetch_instr[`TPU_DST_HI:`TPU_DST_LO];
			dec_src_a	<= fetch_instr[`TPU_SRCA_HI:`TPU_SRCA_LO];
			dec_src_b	<= fetch_instr[`TPU_SRCB_HI:`TPU_SRCB_LO];
			dec_imm		<= fetch_instr[`TPU_IMM_HI:`TPU_IMM_LO];
		end
	end

	// HALT never issues to execute
	a_term_excl: assert property (@(posedge clock) disable iff (reset)
		!(term && dec_valid));

endmodule

// ==== verilog/ifetch.sv ====
// Fetch stage reading the buffer into the instruction register
`timescale 1ns/1ps
`include "tpu_macros.svh"

module ifetch (
	input	logic						clock,
	input	logic						reset,
	input	logic						run,			// Fetch enable from sequencer
	input	logic						flush,			// Halt cleanup
	input	logic						empty,
	input	logic [`TPU_INSTR_W-1:0]	rd_data,
	output	logic						rd_en,
	output	logic						fetch_valid,	// One-cycle strobe
	output	logic [`TPU_INSTR_W-1:0]	fetch_instr
);

	logic						rd_pend;	// Read issued last cycle
	logic [`TPU_INSTR_W-1:0]	instr_q;	// Instruction register
	logic						valid_q;

	// Read whenever running and something waits
	assign rd_en		= run & ~empty;

	assign fetch_valid	= valid_q;
	assign fetch_instr	= instr_q;

	////////////////////////////////////////
	// Retimed request, becomes the capture strobe
	always_ff @(posedge clock) begin
		if (reset) begin
			rd_pend	<= 1'b0;
		end
		else if (flush) begin
			rd_pend	<= 1'b0;				// Read in flight is discarded
		end
		else begin
			rd_pend	<= rd_en;
		end
	end

	// Valid flag for the next stage
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q	<= 1'b0;
		end
		else if (flush) begin
			valid_q	<= 1'b0;				// Flush wins over capture
		end
		else begin
			valid_q	<= rd_pend;
		end
	end

	// Instruction register
	always_ff @(posedge clock) begin
		if (rd_pend & ~flush)
			instr_q	<= rd_data;				// Buffer word is valid now
	end

endmodule

// ==== verilog/instr_buffer.sv ====
// Circular instruction FIFO with registered read and flush
`timescale 1ns/1ps
`include "tpu_macros.svh"

module instr_buffer (
	input	logic						clock,
	input	logic						reset,
	input	logic						flush,		// Drop all entries
	input	logic						wr_en,
	input	logic [`TPU_INSTR_W-1:0]	wr_instr,
	input	logic						rd_en,		// Caller has checked empty
	output	logic [`TPU_INSTR_W-1:0]	rd_data,	// Valid cycle after rd_en
	output	logic						empty,
	output	logic						full
);

	logic [`TPU_INSTR_W-1:0]	mem [0:`TPU_BUF_DEPTH-1];

	logic [`TPU_BUF_AW-1:0]		wr_ptr;
	logic [`TPU_BUF_AW-1:0]		rd_ptr;
	logic [`TPU_BUF_AW:0]		count;		// One extra bit to tell full from empty

	logic						wr_ok;
	logic [`TPU_BUF_AW-1:0]		wr_addr;

	assign empty	= (count == '0);
	assign full		= (count == (`TPU_BUF_AW+1)'(`TPU_BUF_DEPTH));

	assign wr_ok	= wr_en & ~full;				// Write while full is dropped
	assign wr_addr	= flush ? '0 : wr_ptr;			// Write beside flush lands in slot 0

	////////////////////////////////////////
	// Pointers and occupancy
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			count	<= '0;
		end
		else if (flush) begin
			// Old contents are gone, a same-cycle write survives
			rd_ptr	<= '0;
			wr_ptr	<= wr_ok ? `TPU_BUF_AW'(1) : '0;
			count	<= wr_ok ? (`TPU_BUF_AW+1)'(1) : '0;
		end
		else begin
			if (wr_ok)
				wr_ptr	<= wr_ptr + 1'b1;		// Wraps at depth
			if (rd_en)
				rd_ptr	<= rd_ptr + 1'b1;
			case ({wr_ok, rd_en})
				2'b10:		count	<= count + 1'b1;
				2'b01:		count	<= count - 1'b1;
				default:	count	<= count;	// Both or neither
			endcase
		end
	end

	////////////////////////////////////////
	// Storage and read register
	always_ff @(posedge clock) begin
		if (wr_ok)
			mem[wr_addr]	<= wr_instr;
	end

	always_ff @(posedge clock) begin
		if (rd_en)
			rd_data	<= mem[rd_ptr];				// Synchronous read
	end

	// Writer must respect full
	a_no_write_full: assert property (@(posedge clock) disable iff (reset)
		wr_en |-> !full);

	// Fetch gates its read enable with empty
	a_no_read_empty: assert property (@(posedge clock) disable iff (reset)
		rd_en |-> !empty);

endmodule

// ==== verilog/pkg_tpu.sv ====
// Opcode and sequencer state types for the tensor lane
`include "tpu_macros.svh"

package pkg_tpu;

	// Opcodes, numbered from zero in this order
	typedef enum logic [`TPU_OPC_W-1:0] {
		NOP,	// 0 no operation, reports dst unchanged
		ADD,	// 1 a plus b
		SUB,	// 2 a minus b
		MUL,	// 3 low word of a times b
		AND,	// 4 bitwise
		OR,		// 5 bitwise
		XOR,	// 6 bitwise
		SHL,	// 7 a shifted left by b[4:0]
		LDI,	// 8 zero-extended immediate
		HALT	// 9 stops the lane
	} opcode_t;

	// Codes 10 to 15 are treated as NOP by decode

	// Lane sequencer
	typedef enum logic [1:0] {
		IDLE,	// Waiting for start
		RUN,	// Fetching and executing
		DONE	// One cycle of done and flush
	} seq_state_t;

endpackage

// ==== include/tpu_macros.svh ====
// Width, depth and instruction field macros for the tensor lane
`ifndef TPU_MACROS_SVH
`define TPU_MACROS_SVH

////////////////////////////////////////
// Datapath widths
`define TPU_INSTR_W		32		// Instruction word
`define TPU_DATA_W		32		// Register data
`define TPU_REG_N		8		// Register file entries
`define TPU_REG_AW		3		// Register index
`define TPU_OPC_W		4		// Opcode field
`define TPU_IMM_W		16		// Immediate field

////////////////////////////////////////
// Instruction buffer
`define TPU_BUF_DEPTH	16
`define TPU_BUF_AW		4

////////////////////////////////////////
// Field positions in the instruction word
`define TPU_OPC_HI		31
`define TPU_OPC_LO		28
`define TPU_DST_HI		26
`define TPU_DST_LO		24
`define TPU_SRCA_HI		22
`define TPU_SRCA_LO		20
`define TPU_SRCB_HI		18
`define TPU_SRCB_LO		16
`define TPU_IMM_HI		15
`define TPU_IMM_LO		0

`endif
